// ==== logic/smc_pkg.sv ====
/* Static memory controller
   shared widths, timing and types */

`default_nettype none

package smc_pkg;

   // ------------------------------------------------------------------------
   // Widths
   // ------------------------------------------------------------------------
   localparam int ADDR_W  = 16;            // Word address on the pins
   localparam int DATA_W  = 32;            // Bus and memory word
   localparam int LANES   = DATA_W / 8;    // Byte lanes
   localparam int COUNT_W = 8;             // Wait-state count width

   typedef logic [ADDR_W-1:0]  addr_t;     // External word address
   typedef logic [DATA_W-1:0]  data_t;     // Data word
   typedef logic [LANES-1:0]   lane_t;     // Byte selects / active-low enables
   typedef logic [COUNT_W-1:0] count_t;    // Phase cycle counter

   // ------------------------------------------------------------------------
   // Access timing, in sys_clk20 cycles
   // ------------------------------------------------------------------------
   localparam count_t LE_CYCLES   = 8'd2;  // Chip select and address setup
   localparam count_t RW_CYCLES   = 8'd4;  // Wait states plus one
   localparam count_t WETE_CYCLES = 8'd1;  // Write strobe released early
   localparam count_t OETE_CYCLES = 8'd1;  // Read strobe held off

   // Acceptance to ack, start register plus both timed phases
   localparam int ACCESS_LATENCY = 1 + int'(LE_CYCLES) + int'(RW_CYCLES);

   // ------------------------------------------------------------------------
   // Sequencer states
   // ------------------------------------------------------------------------
   typedef enum logic [1:0]
   {
      SMC_IDLE  = 2'd0,                    // No access
      SMC_LE    = 2'd1,                    // Leading edge
      SMC_RW    = 2'd2,                    // Read/write phase
      SMC_FLOAT = 2'd3                     // Bus turnaround
   } smc_state_t;

endpackage

`default_nettype wire

// ==== logic/smc_bus_front.sv ====
/* Wishbone classic slave front end */

`timescale 1ns/1ps
`default_nettype none

module smc_bus_front
(
   input  wire             sys_clk20,
   input  wire             n_sys_reset20,
   // Wishbone slave
   input  wire             wb_cyc,
   input  wire             wb_stb,
   input  wire             wb_we,
   input  wire smc_pkg::addr_t wb_adr,
   input  wire smc_pkg::lane_t wb_sel,
   input  wire smc_pkg::data_t wb_dat_w,
   output logic            wb_ack,
   output smc_pkg::data_t  wb_dat_r,
   // Sequencer and strobe side
   input  wire             rw_last,
   output logic            start,
   output logic            req_we,
   output smc_pkg::lane_t  req_sel,
   // External pins
   output smc_pkg::addr_t  smc_addr,
   output smc_pkg::data_t  smc_data_out,
   input  wire smc_pkg::data_t smc_data_in
);

   logic front_busy;                       // Acceptance up to ack
   logic accept;

   // New request only once the previous ack has gone
   assign accept = wb_cyc & wb_stb & ~wb_ack & ~front_busy;

   // ------------------------------------------------------------------------
   // Control
   // ------------------------------------------------------------------------
   always_ff @(posedge sys_clk20 or negedge n_sys_reset20)
   begin
      if (!n_sys_reset20)
      begin
         front_busy <= 1'b0;
         start      <= 1'b0;
         wb_ack     <= 1'b0;
         req_we     <= 1'b0;
         req_sel    <= '0;
      end
      else
      begin
         start  <= accept;                 // One-cycle pulse
         wb_ack <= rw_last;                // Ack in the float cycle
         if (accept)
         begin
            front_busy <= 1'b1;
            req_we     <= wb_we;           // Held for the whole access
            req_sel    <= wb_sel;
         end
         else if (rw_last)
            front_busy <= 1'b0;
      end
   end

   // Address and write data onto the pins
   always_ff @(posedge sys_clk20)
   begin
      if (accept)
      begin
         smc_addr     <= wb_adr;
         smc_data_out <= wb_dat_w;
      end
   end

   // Read data sampled at the end of the read/write phase
   always_ff @(posedge sys_clk20)
   begin
      if (rw_last && !req_we)
         wb_dat_r <= smc_data_in;
   end

   a_ack_single : assert property (@(posedge sys_clk20) disable iff (!n_sys_reset20)
      wb_ack |=> !wb_ack);

   a_start_once : assert property (@(posedge sys_clk20) disable iff (!n_sys_reset20)
      start |=> (!start throughout wb_ack [->1]));

   // Full round trip through sequencer and back
   a_ack_latency : assert property (@(posedge sys_clk20) disable iff (!n_sys_reset20)
      start |-> ##(smc_pkg::ACCESS_LATENCY) wb_ack);

endmodule

`default_nettype wire

// ==== logic/smc_sequencer.sv ====
/* Access sequencer FSM */

`timescale 1ns/1ps
`default_nettype none

module smc_sequencer
(
   input  wire                 sys_clk20,
   input  wire                 n_sys_reset20,
   input  wire                 start,
   output smc_pkg::smc_state_t state,
   output smc_pkg::smc_state_t next_state,
   output smc_pkg::count_t     phase_count,
   output logic                rw_last
);

   smc_pkg::count_t next_count;            // Counter value after this edge

   // ------------------------------------------------------------------------
   // Next state
   // ------------------------------------------------------------------------
   always_comb
   begin
      next_state = state;                  // Hold by default
      case (state)
         smc_pkg::SMC_IDLE:
         begin
            if (start)
               next_state = smc_pkg::SMC_LE;
         end
         smc_pkg::SMC_LE:
         begin
            if (phase_count == smc_pkg::count_t'(1))
               next_state = smc_pkg::SMC_RW;
         end
         smc_pkg::SMC_RW:
         begin
            if (phase_count == smc_pkg::count_t'(1))
               next_state = smc_pkg::SMC_FLOAT;
         end
         smc_pkg::SMC_FLOAT:
            next_state = smc_pkg::SMC_IDLE;  // Single turnaround cycle
         default:
            next_state = smc_pkg::SMC_IDLE;
      endcase
   end

   // ------------------------------------------------------------------------
   // Phase counter
   // ------------------------------------------------------------------------
   always_comb
   begin
      if (next_state != state)
      begin
         // Load on phase entry
         case (next_state)
            smc_pkg::SMC_LE:    next_count = smc_pkg::LE_CYCLES;
            smc_pkg::SMC_RW:    next_count = smc_pkg::RW_CYCLES;
            smc_pkg::SMC_FLOAT: next_count = smc_pkg::count_t'(1);
            default:            next_count = '0;
         endcase
      end
      else if (phase_count != '0)
         next_count = phase_count - smc_pkg::count_t'(1);  // Count down
      else
         next_count = '0;                  // Idle
   end

   always_ff @(posedge sys_clk20 or negedge n_sys_reset20)
   begin
      if (!n_sys_reset20)
      begin
         state       <= smc_pkg::SMC_IDLE;
         phase_count <= '0;
      end
      else
      begin
         state       <= next_state;
         phase_count <= next_count;
      end
   end

   // Last read/write cycle, front end samples read data here
   assign rw_last = (state == smc_pkg::SMC_RW) &&
                    (phase_count == smc_pkg::count_t'(1));

   // Front end must wait for the previous access to drain
   a_start_idle : assert property (@(posedge sys_clk20) disable iff (!n_sys_reset20)
      start |-> (state == smc_pkg::SMC_IDLE));

endmodule

`default_nettype wire

// ==== logic/smc_strobe.sv ====
/* SRAM strobe generator */

`timescale 1ns/1ps
`default_nettype none

module smc_strobe
(
   input  wire                 sys_clk20,
   input  wire                 n_sys_reset20,
   input  var smc_pkg::smc_state_t next_state,
   input  var smc_pkg::smc_state_t state,
   input  wire smc_pkg::count_t phase_count,
   input  wire                 req_we,
   input  wire smc_pkg::lane_t req_sel,
   output logic                smc_n_cs,
   output logic                smc_n_rd,
   output smc_pkg::lane_t      smc_n_we,
   output logic                smc_n_wr,
   output logic                smc_n_ext_oe,
   output logic                smc_busy
);

   smc_pkg::count_t rw_count_next;         // Cycles left in RW after the edge
   logic            cs_next;
   logic            rd_next;
   logic            wr_next;

   // ------------------------------------------------------------------------
   // Strobe decode, one cycle ahead of the pins
   // ------------------------------------------------------------------------

   // Full count on entry, else one less than now
   assign rw_count_next = (state == smc_pkg::SMC_RW) ?
                          phase_count - smc_pkg::count_t'(1) :
                          smc_pkg::RW_CYCLES;

   assign cs_next = (next_state == smc_pkg::SMC_LE) ||
                    (next_state == smc_pkg::SMC_RW);

   // Read strobe delayed by the output-enable offset
   assign rd_next = (next_state == smc_pkg::SMC_RW) && !req_we &&
                    (rw_count_next <= smc_pkg::RW_CYCLES - smc_pkg::OETE_CYCLES);

   // Write strobe released before the phase ends
   assign wr_next = (next_state == smc_pkg::SMC_RW) && req_we &&
                    (rw_count_next > smc_pkg::WETE_CYCLES);

   // ------------------------------------------------------------------------
   // Registered outputs
   // ------------------------------------------------------------------------
   always_ff @(posedge sys_clk20 or negedge n_sys_reset20)
   begin
      if (!n_sys_reset20)
      begin
         smc_n_cs     <= 1'b1;
         smc_n_rd     <= 1'b1;
         smc_n_we     <= '1;
         smc_n_wr     <= 1'b1;
         smc_n_ext_oe <= 1'b1;
         smc_busy     <= 1'b0;
      end
      else
      begin
         smc_n_cs     <= !cs_next;         // Held over LE and RW
         smc_n_rd     <= !rd_next;
         smc_n_wr     <= !wr_next;
         smc_n_ext_oe <= !wr_next;         // Drive data pins while writing
         smc_busy     <= (next_state != smc_pkg::SMC_IDLE);
         if (wr_next)
            smc_n_we <= ~req_sel;          // Byte lanes from the selects
         else
            smc_n_we <= '1;
      end
   end

   a_rd_wr_excl : assert property (@(posedge sys_clk20) disable iff (!n_sys_reset20)
      !(!smc_n_rd && !smc_n_wr));

endmodule

`default_nettype wire

// ==== logic/smc_top.sv ====
/* Static memory controller top level */

`timescale 1ns/1ps
`default_nettype none

module smc_top
(
   input  wire             sys_clk20,
   input  wire             n_sys_reset20,
   // Wishbone slave
   input  wire             wb_cyc,
   input  wire             wb_stb,
   input  wire             wb_we,
   input  wire smc_pkg::addr_t wb_adr,
   input  wire smc_pkg::lane_t wb_sel,
   input  wire smc_pkg::data_t wb_dat_w,
   output wire smc_pkg::data_t wb_dat_r,
   output wire             wb_ack,
   // SRAM pins
   output wire smc_pkg::addr_t smc_addr,
   output wire smc_pkg::data_t smc_data_out,
   input  wire smc_pkg::data_t smc_data_in,
   output wire             smc_n_cs,
   output wire             smc_n_rd,
   output wire smc_pkg::lane_t smc_n_we,
   output wire             smc_n_wr,
   output wire             smc_n_ext_oe,
   output wire             smc_busy
);

   logic                start;             // Request accepted
   logic                rw_last;           // Final RW cycle
   logic                req_we;
   smc_pkg::lane_t      req_sel;
   smc_pkg::smc_state_t state;
   smc_pkg::smc_state_t next_state;
   smc_pkg::count_t     phase_count;

   // ------------------------------------------------------------------------
   // Front end, sequencer and strobe generator
   // ------------------------------------------------------------------------
   smc_bus_front bus_front_inst (
      .sys_clk20 (sys_clk20),   .n_sys_reset20 (n_sys_reset20),
      .wb_cyc    (wb_cyc),      .wb_stb        (wb_stb),      .wb_we    (wb_we),
      .wb_adr    (wb_adr),      .wb_sel        (wb_sel),      .wb_dat_w (wb_dat_w),
      .wb_ack    (wb_ack),      .wb_dat_r      (wb_dat_r),    .rw_last  (rw_last),
      .start     (start),       .req_we        (req_we),      .req_sel  (req_sel),
      .smc_addr  (smc_addr),    .smc_data_out  (smc_data_out),
      .smc_data_in (smc_data_in));

   smc_sequencer sequencer_inst (
      .sys_clk20 (sys_clk20),   .n_sys_reset20 (n_sys_reset20), .start (start),
      .state     (state),       .next_state    (next_state),
      .phase_count (phase_count), .rw_last     (rw_last));

   smc_strobe strobe_inst (
      .sys_clk20 (sys_clk20),   .n_sys_reset20 (n_sys_reset20),
      .next_state (next_state), .state (state), .phase_count (phase_count),
      .req_we    (req_we),      .req_sel (req_sel),
      .smc_n_cs  (smc_n_cs),    .smc_n_rd (smc_n_rd),   .smc_n_we (smc_n_we),
      .smc_n_wr  (smc_n_wr),    .smc_n_ext_oe (smc_n_ext_oe), .smc_busy (smc_busy));

endmodule

`default_nettype wire

// ==== sim/sram_model.sv ====
/* Asynchronous SRAM model */

`timescale 1ns/1ps
`default_nettype none

module sram_model
(
   input  wire smc_pkg::addr_t smc_addr,
   input  wire smc_pkg::data_t smc_data_out,
   output wire smc_pkg::data_t smc_data_in,
   input  wire                 smc_n_cs,
   input  wire                 smc_n_rd,
   input  wire smc_pkg::lane_t smc_n_we,
   input  wire                 smc_n_wr
);

   smc_pkg::data_t mem [0:(2**smc_pkg::ADDR_W)-1];

   // Fill: address in the upper half, its inverse below
   initial
   begin
      int a;
      for (a = 0; a < 2**smc_pkg::ADDR_W; a++)
         mem[a] = {smc_pkg::addr_t'(a), ~smc_pkg::addr_t'(a)};
   end

   // Level-sensitive write, one byte lane per enable
   always @(smc_n_cs or smc_n_wr or smc_n_we or smc_addr or smc_data_out)
   begin
      int lane;
      if (!smc_n_cs && !smc_n_wr)
      begin
         for (lane = 0; lane < smc_pkg::LANES; lane++)
            if (!smc_n_we[lane])
               mem[smc_addr][8*lane +: 8] = smc_data_out[8*lane +: 8];
      end
   end

   // Output only while the read strobe is low
   assign smc_data_in = (!smc_n_rd) ? mem[smc_addr] : 'x;

endmodule

`default_nettype wire

// ==== sim/smc_tb.sv ====
/* Static memory controller testbench */

`timescale 1ns/1ps
`default_nettype none

module smc_tb;

   localparam int RESET_CYCLES   = 16;
   localparam int WRITE_COUNT    = 64;
   localparam int ACCESS_COUNT   = 2 * WRITE_COUNT;        // Writes plus read-back, at most
   localparam int TIMEOUT_CYCLES = ACCESS_COUNT * (smc_pkg::ACCESS_LATENCY + 4) + 100;
   localparam smc_pkg::addr_t ADDR_MASK = 16'h801f;        // Small space, writes overlap

   logic           sys_clk20 = 1'b0;
   logic           n_sys_reset20;
   logic           wb_cyc;
   logic           wb_stb;
   logic           wb_we;
   smc_pkg::addr_t wb_adr;
   smc_pkg::lane_t wb_sel;
   smc_pkg::data_t wb_dat_w;
   wire smc_pkg::data_t wb_dat_r;
   wire            wb_ack;
   wire smc_pkg::addr_t smc_addr;
   wire smc_pkg::data_t smc_data_out;
   wire smc_pkg::data_t smc_data_in;
   wire            smc_n_cs;
   wire            smc_n_rd;
   wire smc_pkg::lane_t smc_n_we;
   wire            smc_n_wr;
   wire            smc_n_ext_oe;
   wire            smc_busy;

   integer          seed = 5;
   int              error_count = 0;
   int              cycle_count = 0;
   int              mon_cycles = 0;
   logic            cur_we;                 // Request being driven
   smc_pkg::lane_t  cur_sel;
   smc_pkg::addr_t  cur_adr;
   smc_pkg::data_t  cur_dat;
   logic            acc_we = 1'b0;          // Latched at chip select
   smc_pkg::lane_t  acc_sel = '0;
   smc_pkg::addr_t  acc_adr = '0;
   smc_pkg::data_t  acc_dat = '0;
   smc_pkg::count_t cs_run = '0;            // Low-cycle run lengths
   smc_pkg::count_t rd_run = '0;
   smc_pkg::count_t wr_run = '0;
   smc_pkg::count_t oe_run = '0;
   smc_pkg::count_t busy_run = '0;
   smc_pkg::count_t rd_pulses = '0;
   smc_pkg::count_t wr_pulses = '0;
   smc_pkg::count_t oe_pulses = '0;
   logic            ack_prev = 1'b0;
   smc_pkg::addr_t  written_adr [$];        // Shadow memory, address and word
   smc_pkg::data_t  shadow [$];

   smc_top smc_top_inst (
      .sys_clk20 (sys_clk20), .n_sys_reset20 (n_sys_reset20),
      .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
      .wb_sel (wb_sel), .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
      .smc_addr (smc_addr), .smc_data_out (smc_data_out), .smc_data_in (smc_data_in),
      .smc_n_cs (smc_n_cs), .smc_n_rd (smc_n_rd), .smc_n_we (smc_n_we),
      .smc_n_wr (smc_n_wr), .smc_n_ext_oe (smc_n_ext_oe), .smc_busy (smc_busy));

   sram_model sram_inst (
      .smc_addr (smc_addr), .smc_data_out (smc_data_out), .smc_data_in (smc_data_in),
      .smc_n_cs (smc_n_cs), .smc_n_rd (smc_n_rd), .smc_n_we (smc_n_we),
      .smc_n_wr (smc_n_wr));

   always #50 sys_clk20 = ~sys_clk20;       // 100 ns period

   // ------------------------------------------------------------------------
   // Reference model
   // ------------------------------------------------------------------------
   function automatic smc_pkg::data_t fill_word(input smc_pkg::addr_t a);
      return {a, ~a};                       // Same pattern as the SRAM fill
   endfunction

   function automatic smc_pkg::data_t ref_merge(input smc_pkg::data_t old_word,
                                                input smc_pkg::data_t new_word,
                                                input smc_pkg::lane_t sel);
      smc_pkg::data_t merged;
      int             lane;
      merged = old_word;
      for (lane = 0; lane < smc_pkg::LANES; lane++)
         if (sel[lane])
            merged[8*lane +: 8] = new_word[8*lane +: 8];  // Selected lanes only
      return merged;
   endfunction

   function automatic int find_slot(input smc_pkg::addr_t a);
      int slot;
      int i;
      slot = -1;
      for (i = 0; i < written_adr.size(); i++)
         if (written_adr[i] == a)
            slot = i;
      return slot;
   endfunction

   // ------------------------------------------------------------------------
   // Compare tasks
   // ------------------------------------------------------------------------
   task automatic stop_with_failure(input string why);
      $display("TEST FAIL");
      $fatal(1, "%s", why);
   endtask

   task automatic check_data(input smc_pkg::data_t got, input smc_pkg::data_t exp,
                             input string what);
      if (got !== exp)
      begin
         error_count++;
         $display("[ERROR] %0t ns: %s, got %h expected %h", $time, what, got, exp);
         stop_with_failure("data mismatch");
      end
   endtask

   task automatic check_addr(input smc_pkg::addr_t got, input smc_pkg::addr_t exp,
                             input string what);
      if (got !== exp)
      begin
         error_count++;
         $display("[ERROR] %0t ns: %s, got %h expected %h", $time, what, got, exp);
         stop_with_failure("address mismatch");
      end
   endtask

   task automatic check_lanes(input smc_pkg::lane_t got, input smc_pkg::lane_t exp,
                              input string what);
      if (got !== exp)
      begin
         error_count++;
         $display("[ERROR] %0t ns: %s, got %b expected %b", $time, what, got, exp);
         stop_with_failure("byte lane mismatch");
      end
   endtask

   task automatic check_count(input smc_pkg::count_t got, input smc_pkg::count_t exp,
                              input string what);
      if (got !== exp)
      begin
         error_count++;
         $display("[ERROR] %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
         stop_with_failure("cycle count mismatch");
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         error_count++;
         $display("[ERROR] %0t ns: %s, got %b expected %b", $time, what, got, exp);
         stop_with_failure("signal level mismatch");
      end
   endtask

   // One Wishbone access, called on a falling edge
   task automatic run_access(input logic we, input smc_pkg::addr_t adr,
                             input smc_pkg::lane_t sel, input smc_pkg::data_t wdat,
                             output smc_pkg::data_t rdat);
      int waited;
      waited   = 1;
      cur_we   = we;
      cur_sel  = sel;
      cur_adr  = adr;
      cur_dat  = wdat;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_sel   = sel;
      wb_dat_w = wdat;
      @(negedge sys_clk20);                 // Accepted on the edge before this
      while (!wb_ack)
      begin
         @(negedge sys_clk20);
         waited++;
      end
      rdat   = wb_dat_r;                    // Valid in the ack cycle
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      check_count(smc_pkg::count_t'(waited - 1),
                  smc_pkg::count_t'(smc_pkg::ACCESS_LATENCY), "ack latency");
      @(negedge sys_clk20);
   endtask

   // ------------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------------
   initial
   begin
      smc_pkg::data_t rdat;
      smc_pkg::data_t wdat;
      smc_pkg::addr_t adr;
      smc_pkg::lane_t sel;
      int             slot;
      int             i;
      n_sys_reset20 = 1'b0;
      wb_cyc        = 1'b0;
      wb_stb        = 1'b0;
      wb_we         = 1'b0;
      wb_adr        = '0;
      wb_sel        = '0;
      wb_dat_w      = '0;
      cur_we        = 1'b0;
      cur_sel       = '0;
      cur_adr       = '0;
      cur_dat       = '0;
      repeat (RESET_CYCLES) @(negedge sys_clk20);
      n_sys_reset20 = 1'b1;
      @(negedge sys_clk20);

      // Random byte-lane writes
      repeat (WRITE_COUNT)
      begin
         adr  = smc_pkg::addr_t'($random(seed)) & ADDR_MASK;
         wdat = smc_pkg::data_t'($random(seed));
         sel  = smc_pkg::lane_t'($random(seed));
         run_access(1'b1, adr, sel, wdat, rdat);
         slot = find_slot(adr);
         if (slot < 0)
         begin
            written_adr.push_back(adr);
            shadow.push_back(ref_merge(fill_word(adr), wdat, sel));
         end
         else
            shadow[slot] = ref_merge(shadow[slot], wdat, sel);
      end

      // Read back every address written
      for (i = 0; i < written_adr.size(); i++)
      begin
         run_access(1'b0, written_adr[i], '1, '0, rdat);
         check_data(rdat, shadow[i], "read-back data");
      end

      repeat (4) @(negedge sys_clk20);     // Let the monitor close the last pulses
      if (error_count == 0)
      begin
         $display("TEST PASS");
         $finish;
      end
      else
         stop_with_failure("checks failed");
   end

   // ------------------------------------------------------------------------
   // Strobe monitor, sampled mid-cycle
   // ------------------------------------------------------------------------
   always @(negedge sys_clk20)
   begin
      mon_cycles = mon_cycles + 1;
      if (mon_cycles <= RESET_CYCLES + 1)
      begin
         // Reset and the cycle after
         check_flag(smc_n_cs, 1'b1, "n_cs in reset");
         check_flag(smc_n_rd, 1'b1, "n_rd in reset");
         check_flag(smc_n_wr, 1'b1, "n_wr in reset");
         check_lanes(smc_n_we, '1, "n_we in reset");
         check_flag(smc_n_ext_oe, 1'b1, "n_ext_oe in reset");
         check_flag(smc_busy, 1'b0, "busy in reset");
         check_flag(wb_ack, 1'b0, "ack in reset");
      end
      else
      begin
         if (!smc_n_cs && cs_run == 0)
         begin
            acc_we    = cur_we;             // New access begins
            acc_sel   = cur_sel;
            acc_adr   = cur_adr;
            acc_dat   = cur_dat;
            rd_pulses = '0;
            wr_pulses = '0;
            oe_pulses = '0;
         end

         // Pins carry the accepted request
         if (!smc_n_cs)
            check_addr(smc_addr, acc_adr, "address on the pins");
         if (!smc_n_ext_oe)
            check_data(smc_data_out, acc_dat, "write data on the pins");

         if (!smc_n_rd)
         begin
            check_flag(acc_we, 1'b0, "n_rd low on a write");
            rd_run = rd_run + 1'b1;
         end
         else if (rd_run != 0)
         begin
            check_count(rd_run, smc_pkg::RW_CYCLES - smc_pkg::OETE_CYCLES, "n_rd width");
            rd_run    = '0;
            rd_pulses = rd_pulses + 1'b1;
         end

         if (!smc_n_wr)
         begin
            check_flag(acc_we, 1'b1, "n_wr low on a read");
            wr_run = wr_run + 1'b1;
         end
         else if (wr_run != 0)
         begin
            check_count(wr_run, smc_pkg::RW_CYCLES - smc_pkg::WETE_CYCLES, "n_wr width");
            wr_run    = '0;
            wr_pulses = wr_pulses + 1'b1;
         end

         if (!smc_n_ext_oe)
         begin
            check_flag(acc_we, 1'b1, "n_ext_oe low on a read");
            oe_run = oe_run + 1'b1;
         end
         else if (oe_run != 0)
         begin
            check_count(oe_run, smc_pkg::RW_CYCLES - smc_pkg::WETE_CYCLES, "n_ext_oe width");
            oe_run    = '0;
            oe_pulses = oe_pulses + 1'b1;
         end

         // Byte enables follow the selects only under n_wr
         if (!smc_n_wr)
            check_lanes(smc_n_we, ~acc_sel, "n_we during write strobe");
         else
            check_lanes(smc_n_we, '1, "n_we outside write strobe");

         if (!smc_n_cs)
            cs_run = cs_run + 1'b1;
         else if (cs_run != 0)
         begin
            check_count(cs_run, smc_pkg::LE_CYCLES + smc_pkg::RW_CYCLES, "n_cs width");
            check_count(rd_pulses, smc_pkg::count_t'(!acc_we), "n_rd pulses per access");
            check_count(wr_pulses, smc_pkg::count_t'(acc_we), "n_wr pulses per access");
            check_count(oe_pulses, smc_pkg::count_t'(acc_we), "n_ext_oe pulses per access");
            check_flag(smc_busy, 1'b1, "busy in the turnaround cycle");
            cs_run = '0;
         end

         if (smc_busy)
            busy_run = busy_run + 1'b1;
         else if (busy_run != 0)
         begin
            check_count(busy_run, smc_pkg::LE_CYCLES + smc_pkg::RW_CYCLES + 8'd1,
                        "busy width");
            busy_run = '0;
         end

         if (ack_prev)
         begin
            check_flag(wb_ack, 1'b0, "ack longer than one cycle");
            check_flag(smc_busy, 1'b0, "busy in the cycle after ack");
         end
         ack_prev = wb_ack;
      end
   end

   // Run limit
   always @(posedge sys_clk20)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("Run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
         stop_with_failure("timeout");
      end
   end

endmodule

`default_nettype wire

// ==== all.f ====
logic/smc_pkg.sv
logic/smc_bus_front.sv
logic/smc_sequencer.sv
logic/smc_strobe.sv
logic/smc_top.sv
sim/sram_model.sv
sim/smc_tb.sv

// ==== Bender.yml ====
package:
  name: smc

sources:
  - logic/smc_pkg.sv
  - logic/smc_bus_front.sv
  - logic/smc_sequencer.sv
  - logic/smc_strobe.sv
  - logic/smc_top.sv
  - target: simulation
    files:
      - sim/sram_model.sv
      - sim/smc_tb.sv
